// File: c16_mem_top.f
rtl/c16_mem_pkg.sv
rtl/c16_load_pkg.sv
rtl/c16_bus_if.sv
rtl/prg_loader.sv
rtl/ram_arbiter.sv
rtl/rom_store.sv
rtl/rom_banking.sv
rtl/c16_mem_top.sv
testbench/c16_mem_asserts.sv
testbench/c16_mem_tb.sv

// File: Makefile
VERILATOR := verilator
TOP       := c16_mem_tb
FLIST     := c16_mem_top.f
VFLAGS    := --timing --assert -Wno-fatal
SIM_ARGS  := +verilator+error+limit+100
OBJ_DIR   := obj_dir
PASS_MSG  := test passed

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FLIST)

sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) $(SIM_ARGS) | tee /dev/stderr | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// File: testbench/c16_mem_tb.sv
////////////////////////////////////////////////////////////
// C16 memory testbench
// PRG and ROM downloads, banking and arbitration checks
////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module c16_mem_tb
	import c16_mem_pkg::*;
	import c16_load_pkg::*;
();

	// About ten times the length of all tests together
	localparam int MAX_CYCLES = 4000;

	localparam logic [3:0] RGN_RAM  = 4'b0001 << REG_RAM;
	localparam logic [3:0] RGN_LOW  = 4'b0001 << REG_LOW;
	localparam logic [3:0] RGN_HIGH = 4'b0001 << REG_HIGH;
	localparam logic [3:0] RGN_IO   = 4'b0001 << REG_IO;

	// ROM offsets under test
	// The third one gives FC10 in the kernal page
	localparam logic [13:0] OFFS [4] = '{14'h0000, 14'h0123, 14'h3C10, 14'h3FFF};

	logic        clk_sys;
	logic        reset;
	logic        model_i;
	logic        dl_download_i;
	logic [7:0]  dl_index_i;
	logic        dl_wr_i;
	logic [24:0] dl_addr_i;
	logic [7:0]  dl_data_i;
	logic        cpu_req_i;
	logic        cpu_rnw_i;
	logic [15:0] cpu_addr_i;
	logic [7:0]  cpu_wdata_i;
	logic [3:0]  cpu_region_i;
	logic [7:0]  cpu_rdata_o;
	logic        cpu_rvalid_o;
	logic        rom_loaded_o;

	// Reference memory contents and banking state
	logic [7:0] ram_img [0:65535];
	logic [7:0] rom_img [0:ROM_COUNT-1][0:16383];
	logic       exp_model;
	logic [1:0] exp_bank_lo;
	logic [1:0] exp_bank_hi;
	logic       exp_cart_lo;
	logic       exp_cart_hi;
	int         seed = 32'h18c4_0789;
	int         cycle_count = 0;

	c16_mem_top dut (.*);

	initial begin
		clk_sys = 1'b0;
		forever #20 clk_sys = ~clk_sys;
	end

	always @(posedge clk_sys) begin
		cycle_count <= cycle_count + 1;
		if (dut.u_asserts.fail_count != 0) begin
			$display("a timing assertion on the DUT failed");
			abort_run();
		end else if (cycle_count >= MAX_CYCLES) begin
			$display("timeout, the run did not end within %0d cycles", MAX_CYCLES);
			abort_run();
		end
	end

	task automatic abort_run();
		$display("test failed");
		$fatal(1);
	endtask

	task automatic check_byte(input string name, input logic [7:0] exp_val,
			input logic [7:0] act_val);
		chk_byte: assert (act_val === exp_val) else begin
			$display("FAIL %s: expected %h, actual %h", name, exp_val, act_val);
			abort_run();
		end
	endtask

	task automatic next_cycle();
		@(posedge clk_sys);
		#2;
	endtask

	task automatic apply_reset(input logic model);
		model_i   = model;
		reset     = 1'b1;
		// A request during reset gets no answer
		cpu_rnw_i = 1'b1;
		cpu_req_i = 1'b1;
		next_cycle();
		cpu_req_i = 1'b0;
		repeat (2) next_cycle();
		reset       = 1'b0;
		exp_model   = model;
		exp_bank_lo = 2'd0;
		exp_bank_hi = 2'd0;
		exp_cart_lo = 1'b0;
		exp_cart_hi = 1'b0;
	endtask

	////////////////////////////////////////////////////////////
	// Download port
	////////////////////////////////////////////////////////////

	task automatic dl_write(input logic [7:0] index, input logic [24:0] addr,
			input logic [7:0] data);
		dl_index_i = index;
		dl_addr_i  = addr;
		dl_data_i  = data;
		dl_wr_i    = 1'b1;
		next_cycle();
		dl_wr_i = 1'b0;
		next_cycle();
	endtask

	task automatic dl_begin(input logic [7:0] index);
		dl_index_i    = index;
		dl_download_i = 1'b1;
		next_cycle();
	endtask

	// The pointer patch after a PRG download takes 16 cycles
	task automatic prg_finish(input logic [15:0] end_addr);
		dl_download_i = 1'b0;
		repeat (18) next_cycle();
		for (int k = 0; k < 8; k++)
			ram_img[PATCH_ADDR[k]] = k[0] ? end_addr[15:8] : end_addr[7:0];
	endtask

	task automatic prg_load(input logic [15:0] load_addr, input int count);
		logic [7:0] b;
		dl_begin(DL_IDX_PRG);
		dl_write(DL_IDX_PRG, 25'd0, load_addr[7:0]);
		dl_write(DL_IDX_PRG, 25'd1, load_addr[15:8]);
		for (int i = 0; i < count; i++) begin
			b = 8'($random(seed));
			dl_write(DL_IDX_PRG, 25'(i + 2), b);
			ram_img[load_addr + 16'(i)] = b;
		end
		prg_finish(load_addr + 16'(count));
	endtask

	task automatic rom_load(input logic [2:0] id, input logic [7:0] index,
			input logic [10:0] slot, input logic [13:0] off);
		logic [7:0] b;
		b = 8'($random(seed));
		dl_write(index, {slot, off}, b);
		rom_img[id][off] = b;
		if (id == ROM_CART_LO)
			exp_cart_lo = 1'b1;
		if (id == ROM_CART_HI)
			exp_cart_hi = 1'b1;
	endtask

	////////////////////////////////////////////////////////////
	// CPU port
	////////////////////////////////////////////////////////////

	// Byte the CPU should see under the memory map rules
	function automatic logic [7:0] expected_byte(input logic [3:0] region,
			input logic [15:0] addr);
		logic [2:0] id;
		id = ROM_NONE;
		if (region[REG_RAM])
			return ram_img[addr];
		if (region[REG_LOW]) begin
			if (exp_bank_lo == 2'd0)
				id = ROM_BASIC;
			else if (exp_bank_lo == 2'd1 && exp_cart_lo)
				id = ROM_CART_LO;
			else if (exp_bank_lo == 2'd2)
				id = ROM_FUNC_LO;
		end else if (region[REG_HIGH]) begin
			if (addr[15:8] == KERNAL_PAGE || exp_bank_hi == 2'd0)
				id = ROM_KERNAL;
			else if (exp_bank_hi == 2'd1 && exp_cart_hi)
				id = ROM_CART_HI;
			else if (exp_bank_hi == 2'd2)
				id = ROM_FUNC_HI;
		end
		if (id == ROM_NONE)
			return 8'hFF;
		return rom_img[id][addr[13:0]];
	endfunction

	task automatic cpu_access(input string name, input logic rnw, input logic [3:0] region,
			input logic [15:0] addr, input logic [7:0] wdata, output logic [7:0] rdata);
		int waited;
		cpu_req_i    = 1'b1;
		cpu_rnw_i    = rnw;
		cpu_addr_i   = addr;
		cpu_wdata_i  = wdata;
		cpu_region_i = region;
		next_cycle();
		cpu_req_i = 1'b0;
		waited    = 0;
		while (!cpu_rvalid_o) begin
			if (waited == 4) begin
				$display("no read valid after the CPU request in %s", name);
				abort_run();
			end
			next_cycle();
			waited++;
		end
		rdata = cpu_rdata_o;
		next_cycle();
	endtask

	task automatic cpu_read(input string name, input logic [3:0] region,
			input logic [15:0] addr);
		logic [7:0] rdata;
		cpu_access(name, 1'b1, region, addr, 8'h00, rdata);
		check_byte(name, expected_byte(region, addr), rdata);
	endtask

	task automatic cpu_write(input string name, input logic [3:0] region,
			input logic [15:0] addr, input logic [7:0] data);
		logic [7:0] rdata;
		cpu_addr_u  view;
		view.raw = addr;
		cpu_access(name, 1'b0, region, addr, data, rdata);
		if (region[REG_RAM])
			ram_img[addr] = data;
		// Plus/4 bank register sits in page FDD
		if (exp_model && region[REG_IO] && view.f.page == BANK_PAGE) begin
			exp_bank_hi = view.f.bank_hi;
			exp_bank_lo = view.f.bank_lo;
		end
	endtask

	task automatic map_check(input string name);
		for (int k = 0; k < 4; k++) begin
			cpu_read(name, RGN_LOW, {2'b10, OFFS[k]});
			cpu_read(name, RGN_HIGH, {2'b11, OFFS[k]});
		end
		cpu_read(name, RGN_IO, 16'hFD30);
	endtask

	////////////////////////////////////////////////////////////
	// Test sequence
	////////////////////////////////////////////////////////////

	initial begin
		logic [7:0] b;
		logic [7:0] w;
		reset         = 1'b1;
		model_i       = 1'b1;
		dl_download_i = 1'b0;
		dl_index_i    = 8'd0;
		dl_wr_i       = 1'b0;
		dl_addr_i     = '0;
		dl_data_i     = 8'd0;
		cpu_req_i     = 1'b0;
		cpu_rnw_i     = 1'b1;
		cpu_addr_i    = 16'd0;
		cpu_wdata_i   = 8'd0;
		cpu_region_i  = 4'd0;
		apply_reset(1'b1);

		// PRG load at 1001 with 20 bytes
		prg_load(16'h1001, 20);
		for (int i = 0; i < 20; i++)
			cpu_read("prg_data", RGN_RAM, 16'h1001 + 16'(i));
		for (int k = 0; k < 8; k++)
			cpu_read("prg_patch", RGN_RAM, PATCH_ADDR[k]);

		// ROM download and default map
		check_byte("rom_not_loaded", 8'h00, {7'd0, rom_loaded_o});
		dl_begin(DL_IDX_ROM);
		for (int k = 0; k < 4; k++) begin
			rom_load(ROM_KERNAL, DL_IDX_ROM, SLOT_KERNAL, OFFS[k]);
			rom_load(ROM_BASIC, DL_IDX_ROM, SLOT_BASIC, OFFS[k]);
			rom_load(ROM_FUNC_LO, DL_IDX_ROM, SLOT_FUNC_LO, OFFS[k]);
			rom_load(ROM_FUNC_HI, DL_IDX_ROM, SLOT_FUNC_HI, OFFS[k]);
		end
		dl_download_i = 1'b0;
		next_cycle();
		check_byte("rom_loaded", 8'h01, {7'd0, rom_loaded_o});
		map_check("default_map");

		// Plus/4 banking with function low and an empty cartridge slot
		cpu_write("bank_write", RGN_IO, 16'hFDD6, 8'h00);
		map_check("plus4_no_cart");
		dl_begin(DL_IDX_CART);
		for (int k = 0; k < 4; k++)
			rom_load(ROM_CART_HI, DL_IDX_CART, SLOT_CART_HI, OFFS[k]);
		dl_download_i = 1'b0;
		next_cycle();
		map_check("plus4_cart_hi");

		// Reset clears banks and cartridge flags
		apply_reset(1'b1);
		map_check("reset_default");
		cpu_write("bank_write", RGN_IO, 16'hFDD6, 8'h00);
		map_check("reset_cart_cleared");

		// C16 ignores the bank register
		apply_reset(1'b0);
		cpu_write("bank_write", RGN_IO, 16'hFDD6, 8'h00);
		map_check("c16_model");

		// CPU RAM write in the same cycle as a loader RAM write
		dl_begin(DL_IDX_PRG);
		dl_write(DL_IDX_PRG, 25'd0, 8'h00);
		dl_write(DL_IDX_PRG, 25'd1, 8'h20);
		b = 8'($random(seed));
		w = 8'($random(seed));
		dl_addr_i = 25'd2;
		dl_data_i = b;
		dl_wr_i   = 1'b1;
		next_cycle();
		dl_wr_i = 1'b0;
		cpu_write("arb_cpu_write", RGN_RAM, 16'h3000, w);
		ram_img[16'h2000] = b;
		prg_finish(16'h2001);
		cpu_read("arb_loader", RGN_RAM, 16'h2000);
		cpu_read("arb_cpu", RGN_RAM, 16'h3000);
		cpu_read("arb_patch", RGN_RAM, 16'h002D);
		cpu_read("arb_patch", RGN_RAM, 16'h009E);

		next_cycle();
		if (dut.u_asserts.fail_count == 0) begin
			$display("test passed");
			$finish;
		end else begin
			$display("a timing assertion on the DUT failed");
			abort_run();
		end
	end

endmodule

// File: testbench/c16_mem_asserts.sv
////////////////////////////////////////////////////////////
// C16 memory timing checks
// CPU handshake and strobe rules on the top level ports
////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module c16_mem_asserts (
	input logic clk_sys,
	input logic reset,
	input logic cpu_req_i,
	input logic cpu_rvalid_o,
	input logic dl_wr_i
);

	int n_late    = 0;
	int n_extra   = 0;
	int n_reset   = 0;
	int n_req     = 0;
	int n_dl      = 0;
	int fail_count;

	assign fail_count = n_late + n_extra + n_reset + n_req + n_dl;

	// Every request answers in the next cycle
	a_rvalid_after_req: assert property (@(posedge clk_sys) disable iff (reset)
		cpu_req_i |=> cpu_rvalid_o)
	else begin
		n_late = n_late + 1;
		$error("cpu_rvalid_o missing one cycle after cpu_req_i");
	end

	// No valid without a request one cycle before
	a_rvalid_needs_req: assert property (@(posedge clk_sys) disable iff (reset)
		!cpu_req_i |=> !cpu_rvalid_o)
	else begin
		n_extra = n_extra + 1;
		$error("cpu_rvalid_o high without a request");
	end

	a_rvalid_low_in_reset: assert property (@(posedge clk_sys)
		reset |=> !cpu_rvalid_o)
	else begin
		n_reset = n_reset + 1;
		$error("cpu_rvalid_o high during or right after reset");
	end

	// Strobes come at most every other cycle
	a_req_strobe: assert property (@(posedge clk_sys) disable iff (reset)
		cpu_req_i |=> !cpu_req_i)
	else begin
		n_req = n_req + 1;
		$error("cpu_req_i held for two cycles");
	end

	a_dl_wr_strobe: assert property (@(posedge clk_sys)
		dl_wr_i |=> !dl_wr_i)
	else begin
		n_dl = n_dl + 1;
		$error("dl_wr_i held for two cycles");
	end

endmodule

bind c16_mem_top c16_mem_asserts u_asserts (
	.clk_sys      (clk_sys),
	.reset        (reset),
	.cpu_req_i    (cpu_req_i),
	.cpu_rvalid_o (cpu_rvalid_o),
	.dl_wr_i      (dl_wr_i)
);

// File: rtl/c16_mem_top.sv
////////////////////////////////////////////////////////////
// C16 memory subsystem
// Loader, main RAM, ROM store and banking
////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module c16_mem_top
	import c16_mem_pkg::*;
(
	input  logic        clk_sys,
	input  logic        reset,
	input  logic        model_i,
	input  logic        dl_download_i,
	input  logic [7:0]  dl_index_i,
	input  logic        dl_wr_i,
	input  logic [24:0] dl_addr_i,
	input  logic [7:0]  dl_data_i,
	input  logic        cpu_req_i,
	input  logic        cpu_rnw_i,
	input  logic [15:0] cpu_addr_i,
	input  logic [7:0]  cpu_wdata_i,
	input  logic [3:0]  cpu_region_i,
	output logic [7:0]  cpu_rdata_o,
	output logic        cpu_rvalid_o,
	output logic        rom_loaded_o
);

	cpu_bus_if  cpu_bus ();
	mem_port_if ldr_port ();
	dl_port_if  dl_port ();

	logic [7:0]        ram_rdata;
	logic [2:0]        rom_sel;
	logic [ROM_AW-1:0] rom_addr;
	logic [7:0]        rom_rdata;

	assign cpu_bus.req    = cpu_req_i;
	assign cpu_bus.rnw    = cpu_rnw_i;
	assign cpu_bus.addr   = cpu_addr_i;
	assign cpu_bus.wdata  = cpu_wdata_i;
	assign cpu_bus.region = cpu_region_i;

	assign dl_port.download = dl_download_i;
	assign dl_port.index    = dl_index_i;
	assign dl_port.wr       = dl_wr_i;
	assign dl_port.addr     = dl_addr_i;
	assign dl_port.data     = dl_data_i;

	prg_loader u_prg_loader (
		.clk_sys (clk_sys),
		.reset   (reset),
		.dl      (dl_port),
		.ram     (ldr_port)
	);

	ram_arbiter u_ram_arbiter (
		.clk_sys     (clk_sys),
		.reset       (reset),
		.cpu         (cpu_bus),
		.ldr         (ldr_port),
		.ram_rdata_o (ram_rdata)
	);

	rom_store u_rom_store (
		.clk_sys     (clk_sys),
		.dl          (dl_port),
		.rom_sel_i   (rom_sel),
		.rom_addr_i  (rom_addr),
		.rom_rdata_o (rom_rdata)
	);

	rom_banking u_rom_banking (
		.clk_sys      (clk_sys),
		.reset        (reset),
		.model_i      (model_i),
		.dl           (dl_port),
		.cpu          (cpu_bus),
		.ram_rdata_i  (ram_rdata),
		.rom_rdata_i  (rom_rdata),
		.rom_sel_o    (rom_sel),
		.rom_addr_o   (rom_addr),
		.cpu_rdata_o  (cpu_rdata_o),
		.cpu_rvalid_o (cpu_rvalid_o),
		.rom_loaded_o (rom_loaded_o)
	);

endmodule

// File: rtl/rom_banking.sv
////////////////////////////////////////////////////////////
// ROM banking and CPU read path
// Plus/4 bank register, ROM selection and read data mux
////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module rom_banking
	import c16_mem_pkg::*;
	import c16_load_pkg::*;
(
	input  logic              clk_sys,
	input  logic              reset,
	input  logic              model_i,
	dl_port_if.sink           dl,
	cpu_bus_if.monitor        cpu,
	input  logic [7:0]        ram_rdata_i,
	input  logic [7:0]        rom_rdata_i,
	output logic [2:0]        rom_sel_o,
	output logic [ROM_AW-1:0] rom_addr_o,
	output logic [7:0]        cpu_rdata_o,
	output logic              cpu_rvalid_o,
	output logic              rom_loaded_o
);

	logic                    model_q;
	logic                    cart_lo_q;
	logic                    cart_hi_q;
	logic [1:0]              bank_lo_q;
	logic [1:0]              bank_hi_q;
	logic                    rvalid_q;
	logic                    src_ram_q;
	logic                    src_rom_q;
	logic                    rom_loaded_q = 1'b0;
	logic [DL_AW-ROM_AW-1:0] slot;
	logic                    bank_wr;

	assign slot = dl.addr[DL_AW-1:ROM_AW];

	// Bank writes only exist on the Plus/4
	assign bank_wr = model_q && cpu.req && !cpu.rnw && cpu.region[REG_IO]
		&& (cpu.addr.f.page == BANK_PAGE);

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			model_q   <= model_i;
			cart_lo_q <= 1'b0;
			cart_hi_q <= 1'b0;
			bank_lo_q <= 2'd0;
			bank_hi_q <= 2'd0;
			rvalid_q  <= 1'b0;
		end else begin
			rvalid_q <= cpu.req;
			if (dl.wr && (dl.index == DL_IDX_CART) && (slot == SLOT_CART_LO))
				cart_lo_q <= 1'b1;
			if (dl.wr && (dl.index == DL_IDX_CART) && (slot == SLOT_CART_HI))
				cart_hi_q <= 1'b1;
			if (bank_wr) begin
				bank_hi_q <= cpu.addr.f.bank_hi;
				bank_lo_q <= cpu.addr.f.bank_lo;
			end
		end
	end

	// Survives reset since the images stay in place
	always_ff @(posedge clk_sys) begin
		if (dl.wr && (dl.index == DL_IDX_ROM) && (slot == SLOT_KERNAL))
			rom_loaded_q <= 1'b1;
	end

	////////////////////////////////////////////////////////////
	// ROM selection
	////////////////////////////////////////////////////////////

	always_comb begin
		rom_sel_o = ROM_NONE;
		if (cpu.region[REG_LOW]) begin
			case (bank_lo_q)
				2'd0:    rom_sel_o = ROM_BASIC;
				2'd1:    rom_sel_o = cart_lo_q ? ROM_CART_LO : ROM_NONE;
				2'd2:    rom_sel_o = ROM_FUNC_LO;
				default: rom_sel_o = ROM_NONE;
			endcase
		end else if (cpu.region[REG_HIGH]) begin
			// Page FC keeps the kernal visible in every bank
			if (cpu.addr.raw[15:8] == KERNAL_PAGE) begin
				rom_sel_o = ROM_KERNAL;
			end else begin
				case (bank_hi_q)
					2'd0:    rom_sel_o = ROM_KERNAL;
					2'd1:    rom_sel_o = cart_hi_q ? ROM_CART_HI : ROM_NONE;
					2'd2:    rom_sel_o = ROM_FUNC_HI;
					default: rom_sel_o = ROM_NONE;
				endcase
			end
		end
	end

	assign rom_addr_o = cpu.addr.raw[ROM_AW-1:0];

	// Source of the byte returned in the next cycle
	always_ff @(posedge clk_sys) begin
		if (cpu.req) begin
			src_ram_q <= cpu.region[REG_RAM];
			src_rom_q <= cpu.region[REG_LOW] || cpu.region[REG_HIGH];
		end
	end

	assign cpu_rdata_o  = src_ram_q ? ram_rdata_i :
		src_rom_q ? rom_rdata_i : 8'hFF;
	assign cpu_rvalid_o = rvalid_q;
	assign rom_loaded_o = rom_loaded_q;

endmodule

// File: rtl/rom_store.sv
////////////////////////////////////////////////////////////
// ROM store
// Six downloadable 16 KB images behind one read port
////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module rom_store
	import c16_mem_pkg::*;
	import c16_load_pkg::*;
(
	input  logic              clk_sys,
	dl_port_if.sink           dl,
	input  logic [2:0]        rom_sel_i,
	input  logic [ROM_AW-1:0] rom_addr_i,
	output logic [7:0]        rom_rdata_o
);

	logic [DL_AW-ROM_AW-1:0] slot;
	logic                    wr_rom;
	logic                    wr_cart;
	logic [ROM_COUNT-1:0]    wr_en;
	logic [7:0]              rd [ROM_COUNT];
	logic [2:0]              sel_q;

	// Upper download address picks the 16 KB slot
	assign slot    = dl.addr[DL_AW-1:ROM_AW];
	assign wr_rom  = dl.wr && (dl.index == DL_IDX_ROM);
	assign wr_cart = dl.wr && (dl.index == DL_IDX_CART);

	assign wr_en[ROM_KERNAL]  = wr_rom && (slot == SLOT_KERNAL);
	assign wr_en[ROM_BASIC]   = wr_rom && (slot == SLOT_BASIC);
	assign wr_en[ROM_FUNC_LO] = wr_rom && (slot == SLOT_FUNC_LO);
	assign wr_en[ROM_FUNC_HI] = wr_rom && (slot == SLOT_FUNC_HI);
	assign wr_en[ROM_CART_LO] = wr_cart && (slot == SLOT_CART_LO);
	assign wr_en[ROM_CART_HI] = wr_cart && (slot == SLOT_CART_HI);

	for (genvar i = 0; i < ROM_COUNT; i++) begin : g_rom
		logic [7:0] mem [0:2**ROM_AW-1];

		always_ff @(posedge clk_sys) begin
			if (wr_en[i])
				mem[dl.addr[ROM_AW-1:0]] <= dl.data;
			rd[i] <= mem[rom_addr_i];
		end
	end

	always_ff @(posedge clk_sys) begin
		sel_q <= rom_sel_i;
	end

	// ROM_NONE and unused codes read as open bus
	assign rom_rdata_o = (sel_q < ROM_COUNT) ? rd[sel_q] : 8'hFF;

endmodule

// File: rtl/ram_arbiter.sv
////////////////////////////////////////////////////////////
// Main RAM arbiter
// 64 KB RAM shared by the CPU and the loader, CPU first
////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module ram_arbiter
	import c16_mem_pkg::*;
(
	input  logic       clk_sys,
	input  logic       reset,
	cpu_bus_if.monitor cpu,
	mem_port_if.slave  ldr,
	output logic [7:0] ram_rdata_o
);

	logic [7:0] mem [0:2**CPU_AW-1];

	logic              cpu_ram;
	logic              hold_valid;
	logic [CPU_AW-1:0] hold_addr;
	logic [7:0]        hold_data;
	logic              wr_en;
	logic [CPU_AW-1:0] wr_addr;
	logic [7:0]        wr_data;

	assign cpu_ram = cpu.req && cpu.region[REG_RAM];

	// Single write port, CPU then held loader byte then new loader byte
	always_comb begin
		wr_en   = 1'b0;
		wr_addr = ldr.addr;
		wr_data = ldr.wdata;
		if (cpu_ram) begin
			wr_en   = !cpu.rnw;
			wr_addr = cpu.addr.raw;
			wr_data = cpu.wdata;
		end else if (hold_valid) begin
			wr_en   = 1'b1;
			wr_addr = hold_addr;
			wr_data = hold_data;
		end else if (ldr.req) begin
			wr_en = 1'b1;
		end
	end

	// Read returns the old contents on a CPU write
	always_ff @(posedge clk_sys) begin
		if (wr_en)
			mem[wr_addr] <= wr_data;
		if (cpu_ram)
			ram_rdata_o <= mem[cpu.addr.raw];
	end

	////////////////////////////////////////////////////////////
	// Loader hold register
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (reset)
			hold_valid <= 1'b0;
		else if (cpu_ram && ldr.req)
			hold_valid <= 1'b1;
		else if (!cpu_ram)
			hold_valid <= 1'b0;
	end

	always_ff @(posedge clk_sys) begin
		if (cpu_ram && ldr.req) begin
			hold_addr <= ldr.addr;
			hold_data <= ldr.wdata;
		end
	end

endmodule

// File: rtl/prg_loader.sv
////////////////////////////////////////////////////////////
// PRG loader
// Writes PRG payload to RAM at its load address and then
// patches the BASIC end pointers
////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module prg_loader
	import c16_load_pkg::*;
(
	input  logic       clk_sys,
	input  logic       reset,
	dl_port_if.sink    dl,
	mem_port_if.master ram
);

	logic        old_download;
	logic        prg_sel;
	logic [15:0] load_addr;
	logic [3:0]  patch_step;
	logic [2:0]  patch_idx;
	logic [7:0]  patch_byte;

	assign prg_sel = (dl.index == DL_IDX_PRG);

	// Odd steps write, entry number is the step halved
	assign patch_idx  = patch_step[3:1];
	assign patch_byte = patch_idx[0] ? load_addr[15:8] : load_addr[7:0];

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			old_download <= 1'b0;
			patch_step   <= '0;
			ram.req      <= 1'b0;
		end else begin
			old_download <= dl.download;
			ram.req      <= 1'b0;

			if (patch_step != 4'd0)
				patch_step <= patch_step + 4'd1;

			if (dl.download && prg_sel) begin
				patch_step <= '0;
				if (dl.wr && (dl.addr > 1))
					ram.req <= 1'b1;
			end

			// End of a PRG download starts the pointer patch
			if (old_download && !dl.download && prg_sel)
				patch_step <= 4'd1;

			if (patch_step[0])
				ram.req <= 1'b1;
		end
	end

	////////////////////////////////////////////////////////////
	// Address and data path
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (dl.download && prg_sel && dl.wr) begin
			if (dl.addr == 0) begin
				load_addr[7:0] <= dl.data;
			end else if (dl.addr == 1) begin
				load_addr[15:8] <= dl.data;
			end else begin
				ram.addr  <= load_addr;
				ram.wdata <= dl.data;
				load_addr <= load_addr + 16'd1;
			end
		end

		// load_addr now holds the end address
		if (patch_step[0]) begin
			ram.addr  <= PATCH_ADDR[patch_idx];
			ram.wdata <= patch_byte;
		end
	end

endmodule

// File: rtl/c16_bus_if.sv
////////////////////////////////////////////////////////////
// C16 memory side interfaces
// CPU bus, loader RAM port and download port
////////////////////////////////////////////////////////////

`timescale 1ns/10ps

// CPU request, one cycle strobe
interface cpu_bus_if
	import c16_mem_pkg::*;
();
	logic      req;
	logic      rnw;
	cpu_addr_u addr;
	logic [7:0] wdata;
	logic [3:0] region;

	modport monitor (
		input req, rnw, addr, wdata, region
	);
endinterface

// Write-only RAM port for the PRG loader
interface mem_port_if
	import c16_mem_pkg::*;
();
	logic              req;
	logic [CPU_AW-1:0] addr;
	logic [7:0]        wdata;

	modport master (
		output req, addr, wdata
	);
	modport slave (
		input req, addr, wdata
	);
endinterface

// File download stream
interface dl_port_if
	import c16_load_pkg::*;
();
	logic             download;
	logic [7:0]       index;
	logic             wr;
	logic [DL_AW-1:0] addr;
	logic [7:0]       data;

	modport sink (
		input download, index, wr, addr, data
	);
endinterface

// File: rtl/c16_load_pkg.sv
////////////////////////////////////////////////////////////
// Download port definitions
// Index values, ROM slots and BASIC pointer patch addresses
////////////////////////////////////////////////////////////

package c16_load_pkg;

	localparam logic [7:0] DL_IDX_ROM  = 8'd0;
	localparam logic [7:0] DL_IDX_PRG  = 8'd1;
	localparam logic [7:0] DL_IDX_CART = 8'd2;

	localparam int DL_AW = 25;

	// Slots under the ROM index, one per 16 KB image
	localparam logic [10:0] SLOT_KERNAL  = 11'd1;
	localparam logic [10:0] SLOT_BASIC   = 11'd2;
	localparam logic [10:0] SLOT_FUNC_LO = 11'd3;
	localparam logic [10:0] SLOT_FUNC_HI = 11'd4;

	// Slots under the cartridge index
	localparam logic [10:0] SLOT_CART_LO = 11'd0;
	localparam logic [10:0] SLOT_CART_HI = 11'd1;

	// BASIC pointer pairs, low byte at even entries
	localparam logic [15:0] PATCH_ADDR [8] = '{
		16'h002D, 16'h002E, 16'h002F, 16'h0030,
		16'h0031, 16'h0032, 16'h009D, 16'h009E
	};

endpackage

// File: rtl/c16_mem_pkg.sv
////////////////////////////////////////////////////////////
// C16 memory map definitions
// Region select bits, ROM identifiers, banking pages and
// the two views of the CPU address
////////////////////////////////////////////////////////////

package c16_mem_pkg;

	localparam int CPU_AW = 16;
	localparam int ROM_AW = 14;

	// Bit positions in the one-hot region select
	localparam int REG_RAM  = 0;
	localparam int REG_LOW  = 1;
	localparam int REG_HIGH = 2;
	localparam int REG_IO   = 3;

	// ROM identifiers, also the index into the ROM store
	localparam logic [2:0] ROM_KERNAL  = 3'd0;
	localparam logic [2:0] ROM_BASIC   = 3'd1;
	localparam logic [2:0] ROM_FUNC_LO = 3'd2;
	localparam logic [2:0] ROM_FUNC_HI = 3'd3;
	localparam logic [2:0] ROM_CART_LO = 3'd4;
	localparam logic [2:0] ROM_CART_HI = 3'd5;
	localparam logic [2:0] ROM_NONE    = 3'd7;
	localparam int         ROM_COUNT   = 6;

	// Plus/4 bank register page and the fixed kernal page
	localparam logic [11:0] BANK_PAGE   = 12'hFDD;
	localparam logic [7:0]  KERNAL_PAGE = 8'hFC;

	// A write to FDDx carries the new banks in the low nibble
	typedef union packed {
		logic [CPU_AW-1:0] raw;
		struct packed {
			logic [11:0] page;
			logic [1:0]  bank_hi;
			logic [1:0]  bank_lo;
		} f;
	} cpu_addr_u;

endpackage
